// File: tb.f
irq_pkg.sv
mem_bus_if.sv
irq_ctrl.sv
vector_fetch.sv
host_port.sv
bus_arbiter.sv
vector_ram.sv
irq_top.sv
irq_props.sv
tb_irq_top.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_irq_top -f tb.f -o tb_irq_top_sim \
  && ./obj_dir/tb_irq_top_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

// File: tb_irq_top.sv
`default_nettype none

module tb_irq_top
  import irq_pkg::*;
();

  localparam int TIMEOUT  = 40;
  localparam int MAX_ROWS = 16;

  logic                    clk = 1'b0;
  logic                    rst;
  logic [INT_VECT_LEN-1:0] irq_lines;
  logic                    irq_ack;
  logic                    irq_clear;
  logic                    host_we;
  logic [HOST_ADDR_W-1:0]  host_addr;
  logic [XLEN-1:0]         host_wdata;
  logic                    host_ready;
  logic [INT_VECT_LEN-1:0] mask;
  logic                    irq_req;
  irq_state_e              irq_state;
  logic [XLEN-1:0]         handler_addr;
  logic                    handler_valid;

  int              errors;
  int              checks;
  bit              timed_out;
  logic [31:0]     lfsr;
  logic [XLEN-1:0] vec_model [INT_VECT_LEN];

  // scenario table
  int                      n_rows;
  string                   row_name    [MAX_ROWS];
  logic [INT_VECT_LEN-1:0] row_mask    [MAX_ROWS];
  logic [INT_VECT_LEN-1:0] row_lines   [MAX_ROWS];
  bit                      row_req     [MAX_ROWS];
  int                      row_idx     [MAX_ROWS];
  bit                      row_overlap [MAX_ROWS];

  irq_top u_irq_top (
    .clk_i           (clk),
    .rst_i           (rst),
    .irq_lines_i     (irq_lines),
    .irq_ack_i       (irq_ack),
    .irq_clear_i     (irq_clear),
    .host_we_i       (host_we),
    .host_addr_i     (host_addr),
    .host_wdata_i    (host_wdata),
    .host_ready_o    (host_ready),
    .mask_o          (mask),
    .irq_req_o       (irq_req),
    .irq_state_o     (irq_state),
    .handler_addr_o  (handler_addr),
    .handler_valid_o (handler_valid)
  );

  always #10 clk = ~clk;

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic draw_word(output logic [XLEN-1:0] w);
    w = '0;
    for (int b = 0; b < XLEN; b++) begin
      w    = {w[XLEN-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    // handlers are word aligned
    w[1:0] = 2'b00;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic add_row(input string name, input logic [INT_VECT_LEN-1:0] m,
                         input logic [INT_VECT_LEN-1:0] l, input bit req,
                         input int idx, input bit overlap);
    row_name[n_rows]    = name;
    row_mask[n_rows]    = m;
    row_lines[n_rows]   = l;
    row_req[n_rows]     = req;
    row_idx[n_rows]     = idx;
    row_overlap[n_rows] = overlap;
    n_rows++;
  endtask

  // hold the write until host_ready_o is seen high
  task automatic host_write(input logic [HOST_ADDR_W-1:0] a, input logic [XLEN-1:0] d,
                            output int stalls);
    stalls = 0;
    @(negedge clk);
    host_we    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    #1;
    while (!host_ready && stalls < TIMEOUT) begin
      stalls++;
      @(negedge clk);
      #1;
    end
    if (host_ready) begin
      @(posedge clk);
      @(negedge clk);
    end else begin
      timed_out = 1'b1;
      $display("timeout, host_ready_o stayed low for a write to address %0d", a);
    end
    host_we = 1'b0;
  endtask

  task automatic await_handler(output int lat, output logic [XLEN-1:0] addr);
    bit seen;
    seen = 1'b0;
    lat  = 0;
    addr = '0;
    while (!seen && lat < TIMEOUT) begin
      @(negedge clk);
      irq_ack = 1'b0;
      lat++;
      if (handler_valid) begin
        seen = 1'b1;
        addr = handler_addr;
      end
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("timeout, handler_valid_o never pulsed after the acknowledge");
    end
  endtask

  task automatic run_row(input int r);
    int              n;
    int              stalls;
    bit              quiet;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] new_word;
    host_write(MASK_ADDR, XLEN'(row_mask[r]), stalls);
    check_value({row_name[r], " mask"}, 32'(row_mask[r]), 32'(mask));
    irq_lines = row_lines[r];
    if (!row_req[r]) begin
      checks++;
      quiet = 1'b1;
      for (n = 0; n < 20 && quiet; n++) begin
        @(negedge clk);
        if (irq_req) begin
          quiet = 1'b0;
        end
      end
      if (!quiet) begin
        errors++;
        $display("irq_req_o rose in %s with no unmasked line pending", row_name[r]);
      end
      irq_lines = '0;
      return;
    end
    n = 0;
    while (!irq_req && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!irq_req) begin
      timed_out = 1'b1;
      irq_lines = '0;
      $display("timeout, irq_req_o never rose in %s", row_name[r]);
      return;
    end
    new_word = '0;
    stalls   = 0;
    if (row_overlap[r]) begin
      draw_word(new_word);
    end
    irq_ack = 1'b1;
    // second branch lands the table write on the fetch read cycle
    fork
      await_handler(n, addr);
      if (row_overlap[r]) begin
        @(negedge clk);
        host_write(HOST_ADDR_W'(row_idx[r]), new_word, stalls);
      end
    join
    if (timed_out) begin
      irq_lines = '0;
      return;
    end
    check_value({row_name[r], " latency"}, 32'd3, 32'(n));
    check_value({row_name[r], " handler"}, vec_model[row_idx[r]], addr);
    if (row_overlap[r]) begin
      checks++;
      if (stalls < 1) begin
        errors++;
        $display("host_ready_o never dropped for the write during the fetch");
      end
      vec_model[row_idx[r]] = new_word;
    end
    @(negedge clk);
    irq_clear = 1'b1;
    irq_lines = '0;
    @(negedge clk);
    irq_clear = 1'b0;
    check_value({row_name[r], " state"}, 32'(IRQ_IDLE), 32'(irq_state));
  endtask

  initial begin
    logic [XLEN-1:0] w;
    int              stalls;
    rst        = 1'b1;
    irq_lines  = '0;
    irq_ack    = 1'b0;
    irq_clear  = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    n_rows     = 0;
    lfsr       = 32'd48;

    // name, mask, lines, request expected, served index, write during fetch
    add_row("masked_off",         8'h0F, 8'hF0, 1'b0, 0, 1'b0);
    add_row("single_3",           8'hFF, 8'h08, 1'b1, 3, 1'b0);
    add_row("lowest_of_three",    8'hFF, 8'h94, 1'b1, 2, 1'b0);
    add_row("left_pending_4",     8'hFF, 8'h00, 1'b1, 4, 1'b0);
    add_row("left_pending_7",     8'hFF, 8'h00, 1'b1, 7, 1'b0);
    add_row("no_repeat",          8'hFF, 8'h00, 1'b0, 0, 1'b0);
    add_row("upper_mask",         8'hF0, 8'h3C, 1'b1, 4, 1'b0);
    add_row("left_pending_5",     8'hF0, 8'h00, 1'b1, 5, 1'b0);
    add_row("write_during_fetch", 8'hFF, 8'h02, 1'b1, 1, 1'b1);
    add_row("new_entry_1",        8'hFF, 8'h02, 1'b1, 1, 1'b0);
    add_row("lowest_0",           8'hFF, 8'h81, 1'b1, 0, 1'b0);
    add_row("left_pending_7b",    8'hFF, 8'h00, 1'b1, 7, 1'b0);
    add_row("idle_end",           8'hFF, 8'h00, 1'b0, 0, 1'b0);

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("reset ready", 32'd1, 32'(host_ready));
    check_value("reset req", 32'd0, 32'(irq_req));
    check_value("reset valid", 32'd0, 32'(handler_valid));
    check_value("reset mask", 32'd0, 32'(mask));
    check_value("reset state", 32'(IRQ_IDLE), 32'(irq_state));

    for (int i = 0; i < INT_VECT_LEN && !timed_out; i++) begin
      draw_word(w);
      vec_model[i] = w;
      host_write(HOST_ADDR_W'(i), w, stalls);
    end

    // unmapped addresses leave mask and table alone
    host_write(MASK_ADDR, 32'h0000_005A, stalls);
    check_value("mask write", 32'h5A, 32'(mask));
    host_write(5'd20, 32'h0000_00FF, stalls);
    host_write(5'd9, 32'hFFFF_FFF0, stalls);
    check_value("unmapped write", 32'h5A, 32'(mask));

    for (int r = 0; r < n_rows && !timed_out; r++) begin
      run_row(r);
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: irq_props.sv
`default_nettype none

module irq_props
  import irq_pkg::*;
(
  input wire       clk_i,
  input wire       rst_i,
  input wire [1:0] state_i,
  input wire       fetch_start_i,
  input wire       fetch_gnt_i,
  input wire       host_gnt_i,
  input wire       handler_valid_i
);

  // 2'b11 is not a state
  a_state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    state_i != 2'b11)
    else $error("controller state holds the unused encoding");

  // start is registered, so the state one edge back was pending
  a_start_from_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_start_i |-> ($past(state_i) == IRQ_PENDING))
    else $error("fetch start raised outside the pending state");

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(fetch_gnt_i && host_gnt_i))
    else $error("fetcher and host granted in the same cycle");

  a_valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    handler_valid_i == $past(fetch_start_i, 2))
    else $error("handler valid not two cycles after fetch start");

endmodule

bind irq_top irq_props u_irq_props (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .state_i         (irq_state_o),
  .fetch_start_i   (fetch_start),
  .fetch_gnt_i     (fetch_bus.gnt),
  .host_gnt_i      (host_bus.gnt),
  .handler_valid_i (handler_valid_o)
);

`default_nettype wire

// File: irq_top.sv
`default_nettype none

module irq_top
  import irq_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire  [INT_VECT_LEN-1:0] irq_lines_i,
  input  wire                     irq_ack_i,
  input  wire                     irq_clear_i,
  input  wire                     host_we_i,
  input  wire  [HOST_ADDR_W-1:0]  host_addr_i,
  input  wire  [XLEN-1:0]         host_wdata_i,
  output logic                    host_ready_o,
  output logic [INT_VECT_LEN-1:0] mask_o,
  output logic                    irq_req_o,
  output irq_state_e              irq_state_o,
  output logic [XLEN-1:0]         handler_addr_o,
  output logic                    handler_valid_o
);

  logic                    mask_we;
  logic [INT_VECT_LEN-1:0] mask_data;
  logic                    fetch_start;
  logic [IDX_W-1:0]        fetch_idx;

  mem_bus_if host_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if ram_bus ();

  irq_ctrl u_irq_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .irq_lines_i   (irq_lines_i),
    .mask_we_i     (mask_we),
    .mask_data_i   (mask_data),
    .irq_ack_i     (irq_ack_i),
    .irq_clear_i   (irq_clear_i),
    .mask_o        (mask_o),
    .irq_req_o     (irq_req_o),
    .irq_state_o   (irq_state_o),
    .fetch_start_o (fetch_start),
    .fetch_idx_o   (fetch_idx)
  );

  vector_fetch u_vector_fetch (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_start_i   (fetch_start),
    .fetch_idx_i     (fetch_idx),
    .bus             (fetch_bus.requester),
    .handler_addr_o  (handler_addr_o),
    .handler_valid_o (handler_valid_o)
  );

  host_port u_host_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ready_o (host_ready_o),
    .mask_we_o    (mask_we),
    .mask_data_o  (mask_data),
    .bus          (host_bus.requester)
  );

  bus_arbiter u_bus_arbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .fetch_bus (fetch_bus.memory),
    .host_bus  (host_bus.memory),
    .ram_bus   (ram_bus.requester)
  );

  vector_ram u_vector_ram (
    .clk_i (clk_i),
    .bus   (ram_bus.memory)
  );

endmodule

`default_nettype wire

// File: vector_ram.sv
`default_nettype none

module vector_ram
  import irq_pkg::*;
(
  input wire        clk_i,
  mem_bus_if.memory bus
);

  logic [XLEN-1:0] mem_q [INT_VECT_LEN];
  logic [XLEN-1:0] rdata_q;

  // never busy
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[bus.addr] <= bus.wdata;
      end else begin
        rdata_q <= mem_q[bus.addr];
      end
    end
  end

  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input wire           clk_i,
  input wire           rst_i,
  mem_bus_if.memory    fetch_bus,
  mem_bus_if.memory    host_bus,
  mem_bus_if.requester ram_bus
);

  logic fetch_owns_q;

  // fetcher has fixed priority
  assign ram_bus.req   = fetch_bus.req | host_bus.req;
  assign ram_bus.we    = fetch_bus.req ? fetch_bus.we : host_bus.we;
  assign ram_bus.addr  = fetch_bus.req ? fetch_bus.addr : host_bus.addr;
  assign ram_bus.wdata = fetch_bus.req ? fetch_bus.wdata : host_bus.wdata;

  assign fetch_bus.gnt = fetch_bus.req & ram_bus.gnt;
  assign host_bus.gnt  = host_bus.req & ~fetch_bus.req & ram_bus.gnt;

  // who issued the last accepted access
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_owns_q <= 1'b0;
    end else if (ram_bus.req) begin
      fetch_owns_q <= fetch_bus.req;
    end
  end

  // read data back to its owner only
  assign fetch_bus.rdata = fetch_owns_q ? ram_bus.rdata : '0;
  assign host_bus.rdata  = fetch_owns_q ? '0 : ram_bus.rdata;

endmodule

`default_nettype wire

// File: host_port.sv
`default_nettype none

module host_port
  import irq_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     host_we_i,
  input  wire  [HOST_ADDR_W-1:0]  host_addr_i,
  input  wire  [XLEN-1:0]         host_wdata_i,
  output logic                    host_ready_o,
  output logic                    mask_we_o,
  output logic [INT_VECT_LEN-1:0] mask_data_o,
  mem_bus_if.requester            bus
);

  logic             table_sel;
  logic             table_wr;
  logic             req;
  logic             wait_q;
  logic [IDX_W-1:0] hold_addr_q;
  logic [XLEN-1:0]  hold_data_q;

  assign table_sel = (host_addr_i < HOST_ADDR_W'(INT_VECT_LEN));
  assign table_wr  = host_we_i & table_sel;

  // mask writes bypass the bus
  assign mask_we_o   = host_we_i && (host_addr_i == MASK_ADDR);
  assign mask_data_o = host_wdata_i[INT_VECT_LEN-1:0];

  // a denied table write keeps requesting
  assign req       = table_wr | wait_q;
  assign bus.req   = req;
  assign bus.we    = 1'b1;
  assign bus.addr  = wait_q ? hold_addr_q : host_addr_i[IDX_W-1:0];
  assign bus.wdata = wait_q ? hold_data_q : host_wdata_i;

  assign host_ready_o = ~(req & ~bus.gnt);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= req & ~bus.gnt;
    end
  end

  // snapshot of the write on its first cycle
  always_ff @(posedge clk_i) begin
    if (table_wr && !wait_q) begin
      hold_addr_q <= host_addr_i[IDX_W-1:0];
      hold_data_q <= host_wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: vector_fetch.sv
`default_nettype none

module vector_fetch
  import irq_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              fetch_start_i,
  input  wire  [IDX_W-1:0] fetch_idx_i,
  mem_bus_if.requester     bus,
  output logic [XLEN-1:0]  handler_addr_o,
  output logic             handler_valid_o
);

  logic            req_q;
  logic            valid_q;
  logic [XLEN-1:0] addr_q;

  // read only, index stays stable while the line is active
  assign bus.req   = req_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = fetch_idx_i;
  assign bus.wdata = '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (bus.gnt) begin
        req_q <= 1'b0;
      end
      // data lands one cycle after the granted read
      valid_q <= req_q & bus.gnt;
    end
  end

  // keep the address after the valid pulse
  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      addr_q <= bus.rdata;
    end
  end

  // table word goes out in the same cycle as valid
  assign handler_addr_o  = valid_q ? bus.rdata : addr_q;
  assign handler_valid_o = valid_q;

endmodule

`default_nettype wire

// File: irq_ctrl.sv
`default_nettype none

module irq_ctrl
  import irq_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire  [INT_VECT_LEN-1:0] irq_lines_i,
  input  wire                     mask_we_i,
  input  wire  [INT_VECT_LEN-1:0] mask_data_i,
  input  wire                     irq_ack_i,
  input  wire                     irq_clear_i,
  output logic [INT_VECT_LEN-1:0] mask_o,
  output logic                    irq_req_o,
  output irq_state_e              irq_state_o,
  output logic                    fetch_start_o,
  output logic [IDX_W-1:0]        fetch_idx_o
);

  logic [INT_VECT_LEN-1:0] mask_q;
  logic [INT_VECT_LEN-1:0] masked;
  logic [INT_VECT_LEN-1:0] pending_q;
  logic [INT_VECT_LEN-1:0] seen;
  logic [INT_VECT_LEN-1:0] lowest;
  logic [INT_VECT_LEN-1:0] serving_q;
  irq_state_e              state_q;
  logic                    clear_hit;
  logic                    start_q;
  logic [IDX_W-1:0]        idx;

  assign masked    = irq_lines_i & mask_q;
  assign clear_hit = irq_clear_i && (state_q == IRQ_ACTIVE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
    end else if (mask_we_i) begin
      mask_q <= mask_data_i;
    end
  end

  // accumulate every cycle, drop the served bit on clear
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else if (clear_hit) begin
      pending_q <= (pending_q & ~serving_q) | masked;
    end else begin
      pending_q <= pending_q | masked;
    end
  end

  // priority chain, bit 0 wins
  assign seen[0]   = 1'b0;
  assign lowest[0] = pending_q[0];
  for (genvar i = 1; i < INT_VECT_LEN; i++) begin : g_chain
    assign seen[i]   = seen[i-1] | pending_q[i-1];
    assign lowest[i] = pending_q[i] & ~seen[i];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IRQ_IDLE;
      serving_q <= '0;
      start_q   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        IRQ_IDLE: begin
          if (|lowest) begin
            serving_q <= lowest;
            state_q   <= IRQ_PENDING;
          end
        end
        IRQ_PENDING: begin
          if (irq_ack_i) begin
            state_q <= IRQ_ACTIVE;
            start_q <= 1'b1;
          end
        end
        IRQ_ACTIVE: begin
          if (irq_clear_i) begin
            serving_q <= '0;
            state_q   <= IRQ_IDLE;
          end
        end
        default: begin
          state_q <= IRQ_IDLE;
        end
      endcase
    end
  end

  // one-hot to index
  always_comb begin
    idx = '0;
    for (int j = 0; j < INT_VECT_LEN; j++) begin
      if (serving_q[j]) begin
        idx = IDX_W'(j);
      end
    end
  end

  assign mask_o        = mask_q;
  assign irq_req_o     = (state_q == IRQ_PENDING);
  assign irq_state_o   = state_q;
  assign fetch_start_o = start_q;
  assign fetch_idx_o   = idx;

endmodule

`default_nettype wire

// File: mem_bus_if.sv
`default_nettype none

interface mem_bus_if
  import irq_pkg::*;
();

  logic             req;
  logic             we;
  logic [IDX_W-1:0] addr;
  logic [XLEN-1:0]  wdata;
  // combinational from req
  logic             gnt;
  // valid one cycle after a granted read
  logic [XLEN-1:0]  rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport memory (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

`default_nettype wire

// File: irq_pkg.sv
`default_nettype none

package irq_pkg;

  // number of level interrupt lines
  localparam int INT_VECT_LEN = 8;

  // width of a line index
  localparam int IDX_W = $clog2(INT_VECT_LEN);

  // handler address and data word width
  localparam int XLEN = 32;

  // host write address width
  localparam int HOST_ADDR_W = 5;

  // host address of the mask register
  // table entries sit at 0 .. INT_VECT_LEN-1, the rest is unmapped
  localparam logic [HOST_ADDR_W-1:0] MASK_ADDR = 5'd16;

  // serve state of the controller
  // encoding 2'b11 is never used
  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'b00,
    IRQ_PENDING = 2'b01,
    IRQ_ACTIVE  = 2'b10
  } irq_state_e;

endpackage

`default_nettype wire
